/* sim.f */
core_bus_pkg.sv
commit_pkg.sv
line_xfer_if.sv
line_arbiter.sv
axi_burst_master.sv
commit_trace.sv
core_mem_top.sv
core_mem_asserts.sv
tb_core_mem.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_core_mem -f sim.f -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || { cat sim.log; exit 1; }

/* tb_core_mem.sv */
`timescale 1ns/100ps

module tb_core_mem
    import core_bus_pkg::*;
    import commit_pkg::*;
;

    localparam int NUM_ROUNDS = 40;
    localparam int MEM_WORDS  = 1024;
    localparam int MAX_CYCLES = NUM_ROUNDS * 3 * 200 + 1000;  // up to three transfers per round

    logic        aclk;
    logic        rst;
    logic        icache_rd_req_i;
    addr_t       icache_rd_addr_i;
    logic        icache_ret_valid_o;
    line_t       icache_ret_data_o;
    logic        dcache_rd_req_i;
    addr_t       dcache_rd_addr_i;
    logic        dcache_ret_valid_o;
    line_t       dcache_ret_data_o;
    logic        dcache_wr_req_i;
    addr_t       dcache_wr_addr_i;
    line_t       dcache_wr_data_i;
    logic        dcache_wr_done_o;
    addr_t       araddr_o;
    axi_len_t    arlen_o;
    logic [2:0]  arsize_o;
    logic [1:0]  arburst_o;
    logic        arvalid_o;
    logic        arready_i;
    word_t       rdata_i;
    logic        rlast_i;
    logic        rvalid_i;
    logic        rready_o;
    addr_t       awaddr_o;
    axi_len_t    awlen_o;
    logic [2:0]  awsize_o;
    logic [1:0]  awburst_o;
    logic        awvalid_o;
    logic        awready_i;
    word_t       wdata_o;
    logic        wlast_o;
    logic        wvalid_o;
    logic        wready_i;
    logic        bvalid_i;
    logic        bready_o;
    logic        ws_valid_i;
    logic [31:0] wb_pc_i;
    logic [31:0] wb_inst_i;
    logic [3:0]  wb_rf_wen_i;
    logic [4:0]  wb_rf_wnum_i;
    logic [31:0] wb_rf_wdata_i;
    commit_rec_t cmt_o;
    count_t      cycle_cnt_o;
    count_t      instr_cnt_o;

    word_t       mem [MEM_WORDS];      // slave memory, written by the DUT
    word_t       ref_mem [MEM_WORDS];  // expected memory contents
    int          seed = 73321;
    int          cycles = 0;

    // slave bookkeeping
    int          rd_base;
    int          rd_idx;
    logic        rd_active;
    int          wr_base;
    int          wr_idx;
    logic        wr_active;
    logic        b_pend;

    // commit model
    commit_rec_t exp_rec;
    count_t      cyc_m;
    count_t      ins_m;
    logic        have_prev = 1'b0;

    core_mem_top i_core_mem_top (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    function automatic word_t rand_word();
        word_t r;
        r = $random(seed);
        return r;
    endfunction

    function automatic logic rand_bit();
        word_t r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic addr_t rand_line_addr();
        word_t r;
        r = rand_word();
        return {20'd0, r[6:0], 5'd0};  // 128 lines in 4 KiB
    endfunction

    function automatic line_t line_at(addr_t a);
        line_t l;
        for (int k = 0; k < LINE_BEATS; k++) begin
            l[k] = ref_mem[int'(a[11:2]) + k];
        end
        return l;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_line(string name, line_t got, line_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_count(string name, count_t got, count_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_rec(string name, commit_rec_t got, commit_rec_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s", name);
        end
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", what);
    endtask

    // no done may show up while nothing is requested
    task automatic idle_cycles(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge aclk);
            if (icache_ret_valid_o || dcache_ret_valid_o || dcache_wr_done_o) begin
                report_failure("done pulse with no request pending");
            end
        end
    endtask

    // AXI slave with random ready and valid gaps
    always @(posedge aclk) begin
        if (rst) begin
            arready_i <= 1'b0;
            awready_i <= 1'b0;
            wready_i  <= 1'b0;
            rvalid_i  <= 1'b0;
            rlast_i   <= 1'b0;
            bvalid_i  <= 1'b0;
            rd_active = 1'b0;
            wr_active = 1'b0;
            b_pend    = 1'b0;
        end else begin
            if (arvalid_o && arready_i) begin
                check_word("arlen_o", word_t'(arlen_o), 32'd7);
                check_word("arsize_o", word_t'(arsize_o), 32'd2);
                check_word("arburst_o", word_t'(arburst_o), 32'd1);
                check_word("araddr_o[4:0]", araddr_o & 32'h1f, 32'h0);
                rd_base   = int'(araddr_o[11:2]);
                rd_idx    = 0;
                rd_active = 1'b1;
            end
            if (rvalid_i && rready_o) begin
                if (rd_idx == 7) rd_active = 1'b0;  // rlast beat taken
                rd_idx++;
            end
            if (rd_active && rand_bit()) begin
                rvalid_i <= 1'b1;
                rdata_i  <= mem[rd_base + rd_idx];
                rlast_i  <= (rd_idx == 7);
            end else begin
                rvalid_i <= 1'b0;
                rlast_i  <= 1'b0;
            end

            if (awvalid_o && awready_i) begin
                check_word("awlen_o", word_t'(awlen_o), 32'd7);
                check_word("awsize_o", word_t'(awsize_o), 32'd2);
                check_word("awburst_o", word_t'(awburst_o), 32'd1);
                check_word("awaddr_o[4:0]", awaddr_o & 32'h1f, 32'h0);
                wr_base   = int'(awaddr_o[11:2]);
                wr_idx    = 0;
                wr_active = 1'b1;
            end
            if (bvalid_i && bready_o) begin
                bvalid_i <= 1'b0;
            end else if (b_pend && rand_bit()) begin
                bvalid_i <= 1'b1;
                b_pend = 1'b0;
            end
            if (wvalid_o && wready_i) begin
                if (!wr_active) report_failure("W beat outside an accepted write burst");
                check_word("wlast_o", word_t'(wlast_o), word_t'(wr_idx == 7));
                mem[wr_base + wr_idx] = wdata_o;
                if (wr_idx == 7) begin
                    wr_active = 1'b0;
                    b_pend    = 1'b1;
                end
                wr_idx++;
            end
            wready_i  <= wr_active && rand_bit();
            arready_i <= rand_bit();
            awready_i <= rand_bit();
        end
    end

    // commit trace: check last cycle's prediction, then drive new write-back values
    always @(posedge aclk) begin
        if (have_prev) begin
            check_rec("cmt_o", cmt_o, exp_rec);
            check_count("cycle_cnt_o", cycle_cnt_o, cyc_m);
            check_count("instr_cnt_o", instr_cnt_o, ins_m);
        end
        exp_rec.valid = ws_valid_i && !rst;
        exp_rec.pc    = wb_pc_i;
        exp_rec.inst  = wb_inst_i;
        exp_rec.wen   = wb_rf_wen_i;
        exp_rec.wdest = wb_rf_wnum_i;
        exp_rec.wdata = wb_rf_wdata_i;
        if (rst) begin
            cyc_m = '0;
            ins_m = '0;
        end else begin
            cyc_m = cyc_m + 64'd1;
            ins_m = ins_m + count_t'(ws_valid_i);
        end
        have_prev = 1'b1;
        ws_valid_i    <= rand_bit();
        wb_pc_i       <= rand_word();
        wb_inst_i     <= rand_word();
        wb_rf_wen_i   <= 4'(rand_word());
        wb_rf_wnum_i  <= 5'(rand_word());
        wb_rf_wdata_i <= rand_word();
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a transfer never finished", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int    mask;
        int    pend;
        addr_t a_ird;
        addr_t a_drd;
        addr_t a_dwr;
        line_t d_dwr;
        line_t exp_ird;
        line_t exp_drd;

        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = {16'(i) ^ 16'hc3a5, 16'(i * 7 + 3)};
            ref_mem[i] = mem[i];
        end
        rst = 1'b1;
        icache_rd_req_i = 1'b0;
        icache_rd_addr_i = '0;
        dcache_rd_req_i = 1'b0;
        dcache_rd_addr_i = '0;
        dcache_wr_req_i = 1'b0;
        dcache_wr_addr_i = '0;
        dcache_wr_data_i = '0;
        arready_i = 1'b0;
        rdata_i = '0;
        rlast_i = 1'b0;
        rvalid_i = 1'b0;
        awready_i = 1'b0;
        wready_i = 1'b0;
        bvalid_i = 1'b0;
        ws_valid_i = 1'b0;
        wb_pc_i = '0;
        wb_inst_i = '0;
        wb_rf_wen_i = '0;
        wb_rf_wnum_i = '0;
        wb_rf_wdata_i = '0;
        repeat (2) @(posedge aclk);
        rst <= 1'b0;

        for (int r = 0; r < NUM_ROUNDS; r++) begin
            @(posedge aclk);
            // bit 0 dcache write, bit 1 dcache read, bit 2 icache read
            if (r == 0) mask = 4;
            else if (r == 1) mask = 3;
            else mask = int'(rand_word() % 32'd7) + 1;
            a_dwr = rand_line_addr();
            a_drd = (r == 1 || rand_bit()) ? a_dwr : rand_line_addr();
            a_ird = rand_line_addr();
            for (int k = 0; k < LINE_BEATS; k++) d_dwr[k] = rand_word();

            // predict in service order, the writeback lands before any read
            if ((mask & 1) != 0) begin
                for (int k = 0; k < LINE_BEATS; k++) ref_mem[int'(a_dwr[11:2]) + k] = d_dwr[k];
            end
            exp_drd = line_at(a_drd);
            exp_ird = line_at(a_ird);

            dcache_wr_req_i  <= (mask & 1) != 0;
            dcache_wr_addr_i <= a_dwr;
            dcache_wr_data_i <= d_dwr;
            dcache_rd_req_i  <= (mask & 2) != 0;
            dcache_rd_addr_i <= a_drd;
            icache_rd_req_i  <= (mask & 4) != 0;
            icache_rd_addr_i <= a_ird;
            pend = mask;

            while (pend != 0) begin
                @(posedge aclk);
                if (dcache_wr_done_o) begin
                    if ((pend & 1) == 0) report_failure("dcache write done with no write pending");
                    pend = pend & ~1;
                    dcache_wr_req_i <= 1'b0;
                    for (int k = 0; k < LINE_BEATS; k++) begin
                        check_word("slave mem", mem[int'(a_dwr[11:2]) + k], d_dwr[k]);
                    end
                end
                if (dcache_ret_valid_o) begin
                    if ((pend & 2) == 0 || (pend & 1) != 0) begin
                        report_failure("dcache read served out of priority order or unrequested");
                    end
                    pend = pend & ~2;
                    dcache_rd_req_i <= 1'b0;
                    check_line("dcache_ret_data_o", dcache_ret_data_o, exp_drd);
                end
                if (icache_ret_valid_o) begin
                    if ((pend & 4) == 0 || (pend & 3) != 0) begin
                        report_failure("icache read served out of priority order or unrequested");
                    end
                    pend = pend & ~4;
                    icache_rd_req_i <= 1'b0;
                    check_line("icache_ret_data_o", icache_ret_data_o, exp_ird);
                end
            end
            idle_cycles(int'(rand_word() % 32'd4) + 1);
        end

        idle_cycles(10);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* core_mem_asserts.sv */
`timescale 1ns/100ps

module core_mem_asserts
    import core_bus_pkg::*;
(
    input  logic  aclk,
    input  logic  rst,
    input  logic  arvalid_o,
    input  logic  arready_i,
    input  addr_t araddr_o,
    input  logic  awvalid_o,
    input  logic  awready_i,
    input  addr_t awaddr_o,
    input  logic  wvalid_o,
    input  logic  wready_i,
    input  logic  wlast_o,
    input  logic  done_q
);

    beat_cnt_t w_cnt;  // accepted W beats, wraps every burst

    always_ff @(posedge aclk) begin
        if (rst) begin
            w_cnt <= '0;
        end else if (wvalid_o && wready_i) begin
            w_cnt <= w_cnt + 3'd1;
        end
    end

    ar_hold: assert property (@(posedge aclk) disable iff (rst)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else $error("arvalid dropped or araddr changed before arready");

    aw_hold: assert property (@(posedge aclk) disable iff (rst)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
        else $error("awvalid dropped or awaddr changed before awready");

    wlast_pos: assert property (@(posedge aclk) disable iff (rst)
        wvalid_o |-> (wlast_o == (w_cnt == 3'd7)))
        else $error("wlast not on the eighth beat");

    done_pulse: assert property (@(posedge aclk) disable iff (rst)
        done_q |=> !done_q)
        else $error("done high two cycles in a row");

endmodule

bind axi_burst_master core_mem_asserts i_core_mem_asserts (
    .aclk      (aclk),
    .rst       (rst),
    .arvalid_o (arvalid_o),
    .arready_i (arready_i),
    .araddr_o  (araddr_o),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .awaddr_o  (awaddr_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i),
    .wlast_o   (wlast_o),
    .done_q    (done_q)
);

/* core_mem_top.sv */
`timescale 1ns/100ps

module core_mem_top
    import core_bus_pkg::*;
    import commit_pkg::*;
(
    input  logic        aclk,
    input  logic        rst,

    // cache requests
    input  logic        icache_rd_req_i,
    input  addr_t       icache_rd_addr_i,
    output logic        icache_ret_valid_o,
    output line_t       icache_ret_data_o,
    input  logic        dcache_rd_req_i,
    input  addr_t       dcache_rd_addr_i,
    output logic        dcache_ret_valid_o,
    output line_t       dcache_ret_data_o,
    input  logic        dcache_wr_req_i,
    input  addr_t       dcache_wr_addr_i,
    input  line_t       dcache_wr_data_i,
    output logic        dcache_wr_done_o,

    // AXI master
    output addr_t       araddr_o,
    output axi_len_t    arlen_o,
    output logic [2:0]  arsize_o,
    output logic [1:0]  arburst_o,
    output logic        arvalid_o,
    input  logic        arready_i,
    input  word_t       rdata_i,
    input  logic        rlast_i,
    input  logic        rvalid_i,
    output logic        rready_o,
    output addr_t       awaddr_o,
    output axi_len_t    awlen_o,
    output logic [2:0]  awsize_o,
    output logic [1:0]  awburst_o,
    output logic        awvalid_o,
    input  logic        awready_i,
    output word_t       wdata_o,
    output logic        wlast_o,
    output logic        wvalid_o,
    input  logic        wready_i,
    input  logic        bvalid_i,
    output logic        bready_o,

    // write-back trace
    input  logic        ws_valid_i,
    input  logic [31:0] wb_pc_i,
    input  logic [31:0] wb_inst_i,
    input  logic [3:0]  wb_rf_wen_i,
    input  logic [4:0]  wb_rf_wnum_i,
    input  logic [31:0] wb_rf_wdata_i,
    output commit_rec_t cmt_o,
    output count_t      cycle_cnt_o,
    output count_t      instr_cnt_o
);

    line_xfer_if xfer ();  // granted line transfer

    line_arbiter i_line_arbiter (
        .aclk               (aclk),
        .rst                (rst),
        .icache_rd_req_i    (icache_rd_req_i),
        .icache_rd_addr_i   (icache_rd_addr_i),
        .icache_ret_valid_o (icache_ret_valid_o),
        .icache_ret_data_o  (icache_ret_data_o),
        .dcache_rd_req_i    (dcache_rd_req_i),
        .dcache_rd_addr_i   (dcache_rd_addr_i),
        .dcache_ret_valid_o (dcache_ret_valid_o),
        .dcache_ret_data_o  (dcache_ret_data_o),
        .dcache_wr_req_i    (dcache_wr_req_i),
        .dcache_wr_addr_i   (dcache_wr_addr_i),
        .dcache_wr_data_i   (dcache_wr_data_i),
        .dcache_wr_done_o   (dcache_wr_done_o),
        .xfer               (xfer.arb)
    );

    axi_burst_master i_axi_burst_master (
        .aclk      (aclk),
        .rst       (rst),
        .xfer      (xfer.mst),
        .araddr_o  (araddr_o),
        .arlen_o   (arlen_o),
        .arsize_o  (arsize_o),
        .arburst_o (arburst_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rdata_i   (rdata_i),
        .rlast_i   (rlast_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o),
        .awaddr_o  (awaddr_o),
        .awlen_o   (awlen_o),
        .awsize_o  (awsize_o),
        .awburst_o (awburst_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wlast_o   (wlast_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o)
    );

    commit_trace i_commit_trace (
        .aclk          (aclk),
        .rst           (rst),
        .ws_valid_i    (ws_valid_i),
        .wb_pc_i       (wb_pc_i),
        .wb_inst_i     (wb_inst_i),
        .wb_rf_wen_i   (wb_rf_wen_i),
        .wb_rf_wnum_i  (wb_rf_wnum_i),
        .wb_rf_wdata_i (wb_rf_wdata_i),
        .cmt_o         (cmt_o),
        .cycle_cnt_o   (cycle_cnt_o),
        .instr_cnt_o   (instr_cnt_o)
    );

endmodule

/* commit_trace.sv */
`timescale 1ns/100ps

module commit_trace
    import commit_pkg::*;
(
    input  logic        aclk,
    input  logic        rst,

    input  logic        ws_valid_i,
    input  logic [31:0] wb_pc_i,
    input  logic [31:0] wb_inst_i,
    input  logic [3:0]  wb_rf_wen_i,
    input  logic [4:0]  wb_rf_wnum_i,
    input  logic [31:0] wb_rf_wdata_i,

    output commit_rec_t cmt_o,
    output count_t      cycle_cnt_o,
    output count_t      instr_cnt_o
);

    commit_rec_t cmt_q;
    count_t      cycle_q;
    count_t      instr_q;

    // record payload, one stage behind write-back
    always_ff @(posedge aclk) begin
        cmt_q.pc    <= wb_pc_i;
        cmt_q.inst  <= wb_inst_i;
        cmt_q.wen   <= wb_rf_wen_i;
        cmt_q.wdest <= wb_rf_wnum_i;
        cmt_q.wdata <= wb_rf_wdata_i;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            cmt_q.valid <= 1'b0;
            cycle_q     <= '0;
            instr_q     <= '0;
        end else begin
            cmt_q.valid <= ws_valid_i;
            cycle_q     <= cycle_q + 1'b1;
            instr_q     <= instr_q + count_t'(ws_valid_i);  // retired count
        end
    end

    assign cmt_o       = cmt_q;
    assign cycle_cnt_o = cycle_q;
    assign instr_cnt_o = instr_q;

endmodule

/* axi_burst_master.sv */
`timescale 1ns/100ps

module axi_burst_master
    import core_bus_pkg::*;
(
    input  logic        aclk,
    input  logic        rst,

    line_xfer_if.mst    xfer,

    // read address
    output addr_t       araddr_o,
    output axi_len_t    arlen_o,
    output logic [2:0]  arsize_o,
    output logic [1:0]  arburst_o,
    output logic        arvalid_o,
    input  logic        arready_i,
    // read data
    input  word_t       rdata_i,
    input  logic        rlast_i,
    input  logic        rvalid_i,
    output logic        rready_o,
    // write address
    output addr_t       awaddr_o,
    output axi_len_t    awlen_o,
    output logic [2:0]  awsize_o,
    output logic [1:0]  awburst_o,
    output logic        awvalid_o,
    input  logic        awready_i,
    // write data
    output word_t       wdata_o,
    output logic        wlast_o,
    output logic        wvalid_o,
    input  logic        wready_i,
    // write response
    input  logic        bvalid_i,
    output logic        bready_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_t;

    state_t    rd_state;
    state_t    wr_state;
    beat_cnt_t beat_q;
    addr_t     addr_q;
    line_t     wline_q;
    line_t     rline_q;
    logic      done_q;
    logic      start;
    logic      rd_beat;
    logic      wr_beat;

    // done_q blocks a restart while the arbiter still holds req
    assign start   = xfer.req && !done_q && (rd_state == ST_IDLE) && (wr_state == ST_IDLE);
    assign rd_beat = (rd_state == ST_DATA) && rvalid_i;
    assign wr_beat = (wr_state == ST_DATA) && wready_i;

    // read direction
    always_ff @(posedge aclk) begin
        if (rst) begin
            rd_state <= ST_IDLE;
        end else begin
            case (rd_state)
                ST_IDLE: if (start && !xfer.wr) rd_state <= ST_ADDR;
                ST_ADDR: if (arready_i) rd_state <= ST_DATA;
                ST_DATA: if (rd_beat && rlast_i) rd_state <= ST_IDLE;
                default: rd_state <= ST_IDLE;
            endcase
        end
    end

    // write direction, response waits in ST_RESP
    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_state <= ST_IDLE;
        end else begin
            case (wr_state)
                ST_IDLE: if (start && xfer.wr) wr_state <= ST_ADDR;
                ST_ADDR: if (awready_i) wr_state <= ST_DATA;
                ST_DATA: if (wr_beat && wlast_o) wr_state <= ST_RESP;
                ST_RESP: if (bvalid_i) wr_state <= ST_IDLE;
                default: wr_state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            beat_q <= '0;
            done_q <= 1'b0;
        end else begin
            if (start) begin
                beat_q <= '0;
            end else if (rd_beat || wr_beat) begin
                beat_q <= beat_q + 1'b1;
            end
            done_q <= (rd_beat && rlast_i) || ((wr_state == ST_RESP) && bvalid_i);
        end
    end

    // request payload captured once per transfer
    always_ff @(posedge aclk) begin
        if (start) begin
            addr_q  <= xfer.addr;
            wline_q <= xfer.wline;
        end
        if (rd_beat) begin
            rline_q[beat_q] <= rdata_i;  // beats fill words 0..7
        end
    end

    assign xfer.rline = rline_q;
    assign xfer.done  = done_q;

    assign araddr_o  = addr_q;
    assign arlen_o   = AXI_LEN_LINE;
    assign arsize_o  = AXI_SIZE_WORD;
    assign arburst_o = AXI_BURST_INCR;
    assign arvalid_o = (rd_state == ST_ADDR);
    assign rready_o  = (rd_state == ST_DATA);

    assign awaddr_o  = addr_q;
    assign awlen_o   = AXI_LEN_LINE;
    assign awsize_o  = AXI_SIZE_WORD;
    assign awburst_o = AXI_BURST_INCR;
    assign awvalid_o = (wr_state == ST_ADDR);

    assign wvalid_o = (wr_state == ST_DATA);
    assign wdata_o  = wline_q[beat_q];
    assign wlast_o  = wvalid_o && (beat_q == beat_cnt_t'(LINE_BEATS - 1));
    assign bready_o = (wr_state == ST_RESP);

endmodule

/* line_arbiter.sv */
`timescale 1ns/100ps

module line_arbiter
    import core_bus_pkg::*;
(
    input  logic   aclk,
    input  logic   rst,

    input  logic   icache_rd_req_i,
    input  addr_t  icache_rd_addr_i,
    output logic   icache_ret_valid_o,
    output line_t  icache_ret_data_o,

    input  logic   dcache_rd_req_i,
    input  addr_t  dcache_rd_addr_i,
    output logic   dcache_ret_valid_o,
    output line_t  dcache_ret_data_o,

    input  logic   dcache_wr_req_i,
    input  addr_t  dcache_wr_addr_i,
    input  line_t  dcache_wr_data_i,
    output logic   dcache_wr_done_o,

    line_xfer_if.arb xfer
);

    req_src_t grant_q;

    // grant only from idle, hold until the master reports done
    always_ff @(posedge aclk) begin
        if (rst) begin
            grant_q <= SRC_NONE;
        end else if (grant_q == SRC_NONE) begin
            if (dcache_wr_req_i) begin
                grant_q <= SRC_DWR;   // writeback first, frees the victim
            end else if (dcache_rd_req_i) begin
                grant_q <= SRC_DRD;
            end else if (icache_rd_req_i) begin
                grant_q <= SRC_IRD;
            end
        end else if (xfer.done) begin
            grant_q <= SRC_NONE;
        end
    end

    assign xfer.req   = (grant_q != SRC_NONE);
    assign xfer.wr    = (grant_q == SRC_DWR);
    assign xfer.wline = dcache_wr_data_i;  // only looked at for writes

    always_comb begin
        case (grant_q)
            SRC_DWR: xfer.addr = dcache_wr_addr_i;
            SRC_DRD: xfer.addr = dcache_rd_addr_i;
            SRC_IRD: xfer.addr = icache_rd_addr_i;
            default: xfer.addr = '0;
        endcase
    end

    // done goes back only to the owner
    assign icache_ret_valid_o = xfer.done && (grant_q == SRC_IRD);
    assign dcache_ret_valid_o = xfer.done && (grant_q == SRC_DRD);
    assign dcache_wr_done_o   = xfer.done && (grant_q == SRC_DWR);

    // both read ports share the returned line
    assign icache_ret_data_o = xfer.rline;
    assign dcache_ret_data_o = xfer.rline;

endmodule

/* line_xfer_if.sv */
`timescale 1ns/100ps

interface line_xfer_if
    import core_bus_pkg::*;
();

    logic  req;    // held until done
    logic  wr;     // 1 = line writeback
    addr_t addr;   // line aligned
    line_t wline;
    line_t rline;  // valid with done on reads
    logic  done;   // single cycle

    modport arb (
        output req, wr, addr, wline,
        input  rline, done
    );

    modport mst (
        input  req, wr, addr, wline,
        output rline, done
    );

endinterface

/* commit_pkg.sv */
package commit_pkg;

    // one retired instruction as seen at write-back
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [3:0]  wen;    // byte enables of the rf write
        logic [4:0]  wdest;
        logic [31:0] wdata;
    } commit_rec_t;

    typedef logic [63:0] count_t;

endpackage

/* core_bus_pkg.sv */
package core_bus_pkg;

    localparam int LINE_BEATS = 8;

    typedef logic [31:0] addr_t;  // byte address
    typedef logic [31:0] word_t;  // one bus beat

    // word 0 sits at the lowest address
    typedef word_t [LINE_BEATS-1:0] line_t;

    typedef logic [2:0] beat_cnt_t;
    typedef logic [7:0] axi_len_t;

    // fixed burst shape for a line transfer
    localparam axi_len_t   AXI_LEN_LINE   = 8'd7;  // beats minus one
    localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;  // 4 bytes per beat
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

    // requester currently owning the bus
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_DWR,
        SRC_DRD,
        SRC_IRD
    } req_src_t;

endpackage
